//--- filelist.f
+incdir+hw
hw/dll_rx_pkg.sv
hw/dllp_crc16.sv
hw/dllp_decoder.sv
hw/fc_credit_tracker.sv
hw/tlp_seq_checker.sv
hw/dll_rx_top.sv
tb/tb_dll_rx_top.sv

//--- Bender.yml
package:
  name: dll_rx

sources:
  - include_dirs:
      - hw
    files:
      - hw/dll_rx_pkg.sv
      - hw/dllp_crc16.sv
      - hw/dllp_decoder.sv
      - hw/fc_credit_tracker.sv
      - hw/tlp_seq_checker.sv
      - hw/dll_rx_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_dll_rx_top.sv

//--- tb/tb_dll_rx_top.sv
`include "dll_rx_macros.svh"

module tb_dll_rx_top;

    timeunit 1ns;
    timeprecision 1ps;

    import dll_rx_pkg::*;

    logic                  sclk;
    logic                  srst_n;
    pipe_beat_t            pipe;
    acknak_t               acknak;
    fc_state_t             fc_state;
    logic                  init1_done;
    logic                  init2_done;
    tl_hdr_t               tl_hdr;
    logic [`DLL_SEQ_W-1:0] next_rcv_seq;
    logic                  nak_scheduled;

    int                    errors;
    int                    checks;
    int                    seed_val;
    logic [11:0]           exp_lim_hdr  [0:2];  // p, np, cpl
    logic [11:0]           exp_lim_data [0:2];
    logic [11:0]           exp_cons_hdr [0:2];
    logic [11:0]           exp_cons_data[0:2];
    logic [11:0]           last_seq;            // last ack/nak sequence seen
    logic [11:0]           exp_seq;             // model of next_rcv_seq

    dll_rx_top i_dll_rx_top (
        .sclk            (sclk),
        .srst_n          (srst_n),
        .pipe_i          (pipe),
        .acknak_o        (acknak),
        .fc_state_o      (fc_state),
        .init1_done_o    (init1_done),
        .init2_done_o    (init2_done),
        .tl_hdr_o        (tl_hdr),
        .next_rcv_seq_o  (next_rcv_seq),
        .nak_scheduled_o (nak_scheduled)
    );

    initial begin
        sclk = 1'b0;
        forever #50 sclk = ~sclk;
    end

    // ----------------------------------------
    // beat builders
    // ----------------------------------------
    function automatic logic [15:0] dllp_crc(input logic [31:0] body);
        logic [15:0] r;
        logic        fb;
        r = `DLL_CRC_SEED;
        for (int b = 31; b >= 0; b--) begin
            fb = r[15] ^ body[b];                   // msb of body first
            r  = r << 1;
            if (fb) begin
                r = r ^ `DLL_CRC_POLY;
            end
        end
        return ~r;
    endfunction

    function automatic logic [255:0] rand_beat();
        logic [255:0] d;
        for (int w = 0; w < 8; w++) begin
            d[w*32 +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic logic [255:0] make_dllp(input logic [7:0] code, input logic [7:0] hdr_cr,
                                               input logic [11:0] data_cr, input bit corrupt);
        logic [255:0] d;
        d          = rand_beat();
        d[15:0]    = `DLL_DLLP_TOKEN;
        d[23:16]   = code;
        d[29:24]   = hdr_cr[7:2];
        d[39:38]   = hdr_cr[1:0];
        d[35:32]   = data_cr[11:8];                 // also the ack/nak number
        d[47:40]   = data_cr[7:0];
        d[63:48]   = dllp_crc(d[47:16]);
        if (corrupt) begin
            d[63:48] = d[63:48] ^ 16'h0100;
        end
        return d;
    endfunction

    function automatic logic [255:0] make_tlp(input logic [11:0] seq, input logic [127:0] hdr,
                                              input bit header_only);
        logic [255:0] d;
        d          = rand_beat();
        d[159:32]  = hdr;
        d[19:16]   = seq[11:8];
        d[31:24]   = seq[7:0];
        if (header_only) begin
            d[3:0] = 4'hF;
        end
        else begin
            d[3:0] = 4'($urandom_range(14, 1));     // nonzero low nibble, never the token
        end
        return d;
    endfunction

    // kind 0 initfc1, 1 initfc2, 2 updatefc; cls 0 p, 1 np, 2 cpl
    function automatic logic [7:0] fc_type(input int kind, input int cls);
        case (kind)
            0:       return (cls == 0) ? `DLL_TYPE_INITFC1_P :
                            (cls == 1) ? `DLL_TYPE_INITFC1_NP : `DLL_TYPE_INITFC1_CPL;
            1:       return (cls == 0) ? `DLL_TYPE_INITFC2_P :
                            (cls == 1) ? `DLL_TYPE_INITFC2_NP : `DLL_TYPE_INITFC2_CPL;
            default: return (cls == 0) ? `DLL_TYPE_UPDATEFC_P :
                            (cls == 1) ? `DLL_TYPE_UPDATEFC_NP : `DLL_TYPE_UPDATEFC_CPL;
        endcase
    endfunction

    function automatic logic strobe_now(input int which);
        case (which)
            0:       return acknak.ack;
            1:       return acknak.nak;
            default: return tl_hdr.valid;
        endcase
    endfunction

    // ----------------------------------------
    // drive, wait and check
    // ----------------------------------------
    task automatic step(input int n);
        repeat (n) begin
            @(posedge sclk);
            #10;                                    // drive and sample point
        end
    endtask

    task automatic send_beat(input logic [255:0] data);
        pipe.valid = 1'b1;
        pipe.data  = data;
        step(1);
        pipe.valid = 1'b0;
        pipe.data  = '0;
    endtask

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, msg, actual, expected);
        end
    endtask

    task automatic wait_strobe(input int which, input string what, output int cycles);
        int n;
        n = 0;
        while (!strobe_now(which) && n < 20) begin
            step(1);
            n++;
        end
        if (!strobe_now(which)) begin
            errors++;
            $display("timeout waiting for %s", what);
        end
        cycles = n;
    endtask

    task automatic watch_quiet(input int n, input string what);
        int hits;
        hits = 0;
        for (int i = 0; i < n; i++) begin
            step(1);
            if (acknak.ack || acknak.nak || tl_hdr.valid) begin
                hits++;
            end
        end
        check_value(hits, 0, what);
    endtask

    task automatic check_fc_state();
        check_value(fc_state.limit_p.hdr,     exp_lim_hdr[0],   "limit p hdr");
        check_value(fc_state.limit_p.data,    exp_lim_data[0],  "limit p data");
        check_value(fc_state.limit_np.hdr,    exp_lim_hdr[1],   "limit np hdr");
        check_value(fc_state.limit_np.data,   exp_lim_data[1],  "limit np data");
        check_value(fc_state.limit_cpl.hdr,   exp_lim_hdr[2],   "limit cpl hdr");
        check_value(fc_state.limit_cpl.data,  exp_lim_data[2],  "limit cpl data");
        check_value(fc_state.consumed_p.hdr,    exp_cons_hdr[0],  "consumed p hdr");
        check_value(fc_state.consumed_p.data,   exp_cons_data[0], "consumed p data");
        check_value(fc_state.consumed_np.hdr,   exp_cons_hdr[1],  "consumed np hdr");
        check_value(fc_state.consumed_np.data,  exp_cons_data[1], "consumed np data");
        check_value(fc_state.consumed_cpl.hdr,  exp_cons_hdr[2],  "consumed cpl hdr");
        check_value(fc_state.consumed_cpl.data, exp_cons_data[2], "consumed cpl data");
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic initfc_handshake();
        logic [7:0]  hc;
        logic [11:0] dc;
        for (int cls = 0; cls < 3; cls++) begin
            hc = $urandom_range(255, 0);
            dc = $urandom_range(4095, 0);
            send_beat(make_dllp(fc_type(0, cls), hc, dc, 1'b0));
            step(6);
            exp_lim_hdr[cls]  = {4'd0, hc};
            exp_lim_data[cls] = (cls == 1) ? 12'd0 : dc;    // np keeps header only
            check_fc_state();
            check_value(init1_done, cls == 2, "init1_done after initfc1");
            check_value(init2_done, 1'b0, "init2_done before initfc2");
        end
        for (int cls = 0; cls < 3; cls++) begin
            send_beat(make_dllp(fc_type(1, cls), $urandom, $urandom, 1'b0));
            step(6);
            check_value(init2_done, cls == 2, "init2_done after initfc2");
            check_fc_state();
        end
    endtask

    task automatic updatefc_loading();
        logic [7:0]  hc;
        logic [11:0] dc;
        for (int round = 0; round < 2; round++) begin
            for (int cls = 0; cls < 3; cls++) begin
                hc = $urandom_range(255, 0);
                dc = $urandom_range(4095, 0);
                send_beat(make_dllp(fc_type(2, cls), hc, dc, 1'b0));
                step(6);
                exp_cons_hdr[cls]  = {4'd0, hc};
                exp_cons_data[cls] = (cls == 1) ? 12'd0 : dc;
                check_fc_state();
            end
        end
    endtask

    task automatic acknak_reporting();
        logic [11:0] seq;
        int          is_nak;
        int          cycles;
        for (int k = 0; k < 4; k++) begin
            is_nak = k % 2;
            seq    = $urandom_range(4095, 0);
            send_beat(make_dllp(is_nak ? `DLL_TYPE_NAK : `DLL_TYPE_ACK, $urandom, seq, 1'b0));
            wait_strobe(is_nak, is_nak ? "nak strobe" : "ack strobe", cycles);
            check_value(cycles, 2, "ack/nak strobe latency");
            check_value(acknak.seq, seq, "ack/nak sequence");
            check_value(strobe_now(1 - is_nak), 1'b0, "opposite strobe");
            step(1);
            check_value(strobe_now(is_nak), 1'b0, "ack/nak strobe width");
            step(2);
            check_value(acknak.seq, seq, "ack/nak sequence hold");
            last_seq = seq;
        end
    endtask

    task automatic crc_rejection();
        send_beat(make_dllp(`DLL_TYPE_ACK, $urandom, last_seq + 12'd1, 1'b1));
        watch_quiet(6, "strobe after bad crc ack");
        check_value(acknak.seq, last_seq, "sequence after bad crc ack");
        send_beat(make_dllp(fc_type(2, 0), $urandom, $urandom, 1'b1));
        watch_quiet(6, "strobe after bad crc updatefc");
        check_fc_state();
    endtask

    task automatic deliver_in_order(input string what);
        logic [127:0] hdr;
        int           cycles;
        hdr = {$urandom, $urandom, $urandom, $urandom};
        send_beat(make_tlp(exp_seq, hdr, 1'b1));
        wait_strobe(2, what, cycles);
        check_value(cycles, 2, "header strobe latency");
        check_value(tl_hdr.hdr, hdr, "delivered header");
        exp_seq = exp_seq + 12'd1;
        check_value(next_rcv_seq, exp_seq, "next_rcv_seq after delivery");
        check_value(nak_scheduled, 1'b0, "nak flag after in-order tlp");
        step(1);
        check_value(tl_hdr.valid, 1'b0, "header strobe width");
        step(1);
    endtask

    task automatic tlp_sequencing();
        for (int k = 0; k < 4; k++) begin
            deliver_in_order("tlp header strobe");
        end
        send_beat(make_tlp(exp_seq + 12'd5, {$urandom, $urandom, $urandom, $urandom}, 1'b1));
        watch_quiet(6, "header strobe for out-of-order tlp");
        check_value(nak_scheduled, 1'b1, "nak flag after out-of-order tlp");
        check_value(next_rcv_seq, exp_seq, "next_rcv_seq after out-of-order tlp");
        deliver_in_order("tlp header strobe after nak");
    endtask

    task automatic ignored_traffic();
        for (int k = 0; k < 3; k++) begin
            send_beat(make_tlp(exp_seq, {$urandom, $urandom, $urandom, $urandom}, 1'b0));
            watch_quiet(4, "strobe for tlp without header-only marker");
        end
        send_beat(make_dllp(8'h30, $urandom, $urandom, 1'b0));  // unknown dllp type
        watch_quiet(6, "strobe for unknown dllp type");
        check_fc_state();
        check_value(acknak.seq, last_seq, "sequence after ignored traffic");
        check_value(next_rcv_seq, exp_seq, "next_rcv_seq after ignored traffic");
        check_value(nak_scheduled, 1'b0, "nak flag after ignored traffic");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        errors   = 0;
        checks   = 0;
        seed_val = $urandom(69);
        srst_n   = 1'b0;
        pipe     = '0;
        last_seq = '0;
        exp_seq  = '0;
        for (int c = 0; c < 3; c++) begin
            exp_lim_hdr[c]   = '0;
            exp_lim_data[c]  = '0;
            exp_cons_hdr[c]  = '0;
            exp_cons_data[c] = '0;
        end
        repeat (16) @(posedge sclk);
        #10;
        srst_n = 1'b1;
        step(2);
        check_fc_state();                           // all credits zero out of reset
        check_value(next_rcv_seq, 12'd0, "next_rcv_seq after reset");

        initfc_handshake();
        updatefc_loading();
        acknak_reporting();
        crc_rejection();
        tlp_sequencing();
        ignored_traffic();

        $display("run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end
        else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- hw/dll_rx_top.sv
`include "dll_rx_macros.svh"

module dll_rx_top (
    input  logic                   sclk,
    input  logic                   srst_n,
    // ----------------------------------------
    // pipe receive side
    // ----------------------------------------
    input  dll_rx_pkg::pipe_beat_t pipe_i,
    // ----------------------------------------
    // dllp results
    // ----------------------------------------
    output dll_rx_pkg::acknak_t    acknak_o,
    output dll_rx_pkg::fc_state_t  fc_state_o,
    output logic                   init1_done_o,
    output logic                   init2_done_o,
    // ----------------------------------------
    // tlp results
    // ----------------------------------------
    output dll_rx_pkg::tl_hdr_t    tl_hdr_o,
    output logic [`DLL_SEQ_W-1:0]  next_rcv_seq_o,
    output logic                   nak_scheduled_o
);

    import dll_rx_pkg::*;

    fc_update_t fc_update;                      // one-cycle event, decoder to tracker

    // both paths see every beat and pick their own by framing
    dllp_decoder i_dllp_decoder (
        .sclk        (sclk),
        .srst_n      (srst_n),
        .pipe_i      (pipe_i),
        .fc_update_o (fc_update),
        .acknak_o    (acknak_o)
    );

    fc_credit_tracker i_fc_credit_tracker (
        .sclk         (sclk),
        .srst_n       (srst_n),
        .fc_update_i  (fc_update),
        .fc_state_o   (fc_state_o),
        .init1_done_o (init1_done_o),
        .init2_done_o (init2_done_o)
    );

    tlp_seq_checker i_tlp_seq_checker (
        .sclk            (sclk),
        .srst_n          (srst_n),
        .pipe_i          (pipe_i),
        .tl_hdr_o        (tl_hdr_o),
        .next_rcv_seq_o  (next_rcv_seq_o),
        .nak_scheduled_o (nak_scheduled_o)
    );

endmodule

//--- hw/tlp_seq_checker.sv
`include "dll_rx_macros.svh"

module tlp_seq_checker (
    input  logic                   sclk,
    input  logic                   srst_n,
    input  dll_rx_pkg::pipe_beat_t pipe_i,
    output dll_rx_pkg::tl_hdr_t    tl_hdr_o,
    output logic [`DLL_SEQ_W-1:0]  next_rcv_seq_o,
    output logic                   nak_scheduled_o
);

    import dll_rx_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEQ_CHECK,
        S_DELIVER
    } state_t;

    state_t                 state_q, state_n;
    logic [159:16]          tlp_q;              // seq field and header of the held tlp
    logic [`DLL_SEQ_W-1:0]  next_rcv_seq_q, next_rcv_seq_n;
    logic [`DLL_SEQ_W-1:0]  tlp_seq;
    logic                   nak_q, nak_n;
    logic                   hdr_valid_q;
    logic [`DLL_HDR_W-1:0]  hdr_q;
    logic                   capture;

    // header-only tlps carry all ones in bits 3:0
    assign capture = (state_q == S_IDLE) && pipe_i.valid &&
                     (pipe_i.data[15:0] != `DLL_DLLP_TOKEN) &&
                     (pipe_i.data[3:0] == 4'b1111);

    assign tlp_seq = {tlp_q[19:16], tlp_q[31:24]};

    // ----------------------------------------
    // fsm and sequence check
    // ----------------------------------------
    always_comb begin
        state_n        = state_q;
        next_rcv_seq_n = next_rcv_seq_q;
        nak_n          = nak_q;
        case (state_q)
            S_IDLE: begin
                if (capture) begin
                    state_n = S_SEQ_CHECK;
                end
            end
            S_SEQ_CHECK: begin
                if (tlp_seq == next_rcv_seq_q) begin
                    next_rcv_seq_n = next_rcv_seq_q + 1'b1;
                    nak_n          = 1'b0;
                    state_n        = S_DELIVER;
                end
                else begin
                    nak_n   = 1'b1;                 // out of order, header dropped
                    state_n = S_IDLE;
                end
            end
            S_DELIVER: state_n = S_IDLE;
            default:   state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            state_q        <= S_IDLE;
            next_rcv_seq_q <= '0;
            nak_q          <= 1'b0;
            hdr_valid_q    <= 1'b0;
        end
        else begin
            state_q        <= state_n;
            next_rcv_seq_q <= next_rcv_seq_n;
            nak_q          <= nak_n;
            hdr_valid_q    <= (state_q == S_DELIVER);   // one-cycle strobe
        end
    end

    always_ff @(posedge sclk) begin
        if (capture) begin
            tlp_q <= pipe_i.data[159:16];
        end
        if (state_q == S_DELIVER) begin
            hdr_q <= tlp_q[159:32];
        end
    end

    assign tl_hdr_o        = '{valid: hdr_valid_q, hdr: hdr_q};
    assign next_rcv_seq_o  = next_rcv_seq_q;
    assign nak_scheduled_o = nak_q;

endmodule

//--- hw/fc_credit_tracker.sv
module fc_credit_tracker (
    input  logic                   sclk,
    input  logic                   srst_n,
    input  dll_rx_pkg::fc_update_t fc_update_i,
    output dll_rx_pkg::fc_state_t  fc_state_o,
    output logic                   init1_done_o,
    output logic                   init2_done_o
);

    import dll_rx_pkg::*;

    fc_state_t  state_q;
    logic [2:0] init1_q;                        // p, np, cpl order as in fc_sel_t
    logic [2:0] init2_q;
    fc_class_t  upd_val;

    assign upd_val = fc_update_i.value;

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            state_q <= '0;
            init1_q <= '0;
            init2_q <= '0;
        end
        else begin
            // ----------------------------------------
            // initfc1 loads limits
            // ----------------------------------------
            if (fc_update_i.kind.init1) begin
                init1_q <= init1_q | fc_update_i.cls;
                if (fc_update_i.cls.p) begin
                    state_q.limit_p <= upd_val;
                end
                if (fc_update_i.cls.np) begin
                    state_q.limit_np.hdr <= upd_val.hdr;    // np has header credit only
                end
                if (fc_update_i.cls.cpl) begin
                    state_q.limit_cpl <= upd_val;
                end
            end
            // ----------------------------------------
            // updatefc loads consumed credits
            // ----------------------------------------
            if (fc_update_i.kind.update) begin
                if (fc_update_i.cls.p) begin
                    state_q.consumed_p <= upd_val;
                end
                if (fc_update_i.cls.np) begin
                    state_q.consumed_np.hdr <= upd_val.hdr;
                end
                if (fc_update_i.cls.cpl) begin
                    state_q.consumed_cpl <= upd_val;
                end
            end
            if (fc_update_i.kind.init2) begin
                init2_q <= init2_q | fc_update_i.cls;
            end
        end
    end

    assign fc_state_o   = state_q;
    assign init1_done_o = &init1_q;             // all three classes seen
    assign init2_done_o = &init2_q;

endmodule

//--- hw/dllp_decoder.sv
`include "dll_rx_macros.svh"

module dllp_decoder (
    input  logic                   sclk,
    input  logic                   srst_n,
    input  dll_rx_pkg::pipe_beat_t pipe_i,
    output dll_rx_pkg::fc_update_t fc_update_o,
    output dll_rx_pkg::acknak_t    acknak_o
);

    import dll_rx_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CRC_CHECK,
        S_DECODE
    } state_t;

    state_t       state_q, state_n;
    logic [63:16] dllp_q;                       // type, fields and crc of the held dllp
    logic [15:0]  crc_calc;
    logic         capture;
    fc_class_t    fields;
    fc_update_t   fc_update_q, fc_update_n;
    acknak_t      acknak_q, acknak_n;

    dllp_crc16 i_dllp_crc16 (
        .body_i (dllp_q[47:16]),
        .crc_o  (crc_calc)
    );

    assign capture = (state_q == S_IDLE) && pipe_i.valid &&
                     (pipe_i.data[15:0] == `DLL_DLLP_TOKEN);

    assign fields.hdr  = {4'd0, dllp_q[29:24], dllp_q[39:38]};
    assign fields.data = {dllp_q[35:32], dllp_q[47:40]};    // also the ack/nak seq

    // ----------------------------------------
    // fsm and decode
    // ----------------------------------------
    always_comb begin
        state_n     = state_q;
        fc_update_n = '0;
        acknak_n    = '{ack: 1'b0, nak: 1'b0, seq: acknak_q.seq};
        case (state_q)
            S_IDLE: begin
                if (capture) begin
                    state_n = S_CRC_CHECK;
                end
            end
            S_CRC_CHECK: begin
                if (crc_calc == dllp_q[63:48]) begin
                    state_n = S_DECODE;
                end
                else begin
                    state_n = S_IDLE;               // bad crc, drop silently
                end
            end
            S_DECODE: begin
                state_n           = S_IDLE;
                fc_update_n.value = fields;
                case (dllp_q[23:16])
                    `DLL_TYPE_INITFC1_P, `DLL_TYPE_INITFC1_NP, `DLL_TYPE_INITFC1_CPL:
                        fc_update_n.kind.init1 = 1'b1;
                    `DLL_TYPE_INITFC2_P, `DLL_TYPE_INITFC2_NP, `DLL_TYPE_INITFC2_CPL:
                        fc_update_n.kind.init2 = 1'b1;
                    `DLL_TYPE_UPDATEFC_P, `DLL_TYPE_UPDATEFC_NP, `DLL_TYPE_UPDATEFC_CPL:
                        fc_update_n.kind.update = 1'b1;
                    `DLL_TYPE_ACK: begin
                        acknak_n.ack = 1'b1;
                        acknak_n.seq = fields.data;
                    end
                    `DLL_TYPE_NAK: begin
                        acknak_n.nak = 1'b1;
                        acknak_n.seq = fields.data;
                    end
                    default: ;                      // unknown type, no event
                endcase
                case (dllp_q[23:16])
                    `DLL_TYPE_INITFC1_P, `DLL_TYPE_INITFC2_P, `DLL_TYPE_UPDATEFC_P:
                        fc_update_n.cls.p = 1'b1;
                    `DLL_TYPE_INITFC1_NP, `DLL_TYPE_INITFC2_NP, `DLL_TYPE_UPDATEFC_NP:
                        fc_update_n.cls.np = 1'b1;
                    `DLL_TYPE_INITFC1_CPL, `DLL_TYPE_INITFC2_CPL, `DLL_TYPE_UPDATEFC_CPL:
                        fc_update_n.cls.cpl = 1'b1;
                    default: ;
                endcase
            end
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (!srst_n) begin
            state_q     <= S_IDLE;
            fc_update_q <= '0;
            acknak_q    <= '0;
        end
        else begin
            state_q     <= state_n;
            fc_update_q <= fc_update_n;
            acknak_q    <= acknak_n;
        end
    end

    always_ff @(posedge sclk) begin
        if (capture) begin
            dllp_q <= pipe_i.data[63:16];
        end
    end

    assign fc_update_o = fc_update_q;
    assign acknak_o    = acknak_q;

endmodule

//--- hw/dllp_crc16.sv
`include "dll_rx_macros.svh"

module dllp_crc16 (
    input  logic [31:0] body_i,
    output logic [15:0] crc_o
);

    logic [15:0] crc;

    // msb first, one shift-and-xor per body bit
    always_comb begin
        crc = `DLL_CRC_SEED;
        for (int i = 31; i >= 0; i--) begin
            if ((crc[15] ^ body_i[i]) == 1'b1) begin
                crc = {crc[14:0], 1'b0} ^ `DLL_CRC_POLY;
            end
            else begin
                crc = {crc[14:0], 1'b0};
            end
        end
        crc_o = ~crc;                           // sent inverted on the link
    end

endmodule

//--- hw/dll_rx_pkg.sv
`include "dll_rx_macros.svh"

package dll_rx_pkg;

    // ----------------------------------------
    // pipe side
    // ----------------------------------------
    typedef struct packed {
        logic                    valid;
        logic [`DLL_PIPE_W-1:0]  data;
    } pipe_beat_t;

    // ----------------------------------------
    // flow control
    // ----------------------------------------
    typedef struct packed {
        logic [`DLL_CREDIT_W-1:0] hdr;
        logic [`DLL_CREDIT_W-1:0] data;
    } fc_class_t;

    typedef struct packed {
        logic init1;
        logic init2;
        logic update;
    } fc_kind_t;                                // one-hot, all zero means no event

    typedef struct packed {
        logic p;
        logic np;
        logic cpl;
    } fc_sel_t;                                 // one-hot traffic class

    typedef struct packed {
        fc_kind_t  kind;
        fc_sel_t   cls;
        fc_class_t value;
    } fc_update_t;

    typedef struct packed {
        fc_class_t limit_p;
        fc_class_t limit_np;                    // data half stays zero
        fc_class_t limit_cpl;
        fc_class_t consumed_p;
        fc_class_t consumed_np;                 // data half stays zero
        fc_class_t consumed_cpl;
    } fc_state_t;

    // ----------------------------------------
    // retry and transaction layer side
    // ----------------------------------------
    typedef struct packed {
        logic                   ack;
        logic                   nak;
        logic [`DLL_SEQ_W-1:0]  seq;
    } acknak_t;

    typedef struct packed {
        logic                   valid;
        logic [`DLL_HDR_W-1:0]  hdr;
    } tl_hdr_t;

endpackage

//--- hw/dll_rx_macros.svh
`ifndef DLL_RX_MACROS_SVH
`define DLL_RX_MACROS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define DLL_PIPE_W             256
`define DLL_CREDIT_W           12
`define DLL_SEQ_W              12
`define DLL_HDR_W              128

// ----------------------------------------
// framing and dllp crc
// ----------------------------------------
`define DLL_DLLP_TOKEN         16'hACF0
`define DLL_CRC_POLY           16'h100B
`define DLL_CRC_SEED           16'hFFFF

// ----------------------------------------
// dllp type codes, bits 23:16
// ----------------------------------------
`define DLL_TYPE_ACK           8'h00
`define DLL_TYPE_NAK           8'h10
`define DLL_TYPE_INITFC1_P     8'h40
`define DLL_TYPE_INITFC1_NP    8'h50
`define DLL_TYPE_INITFC1_CPL   8'h60
`define DLL_TYPE_UPDATEFC_P    8'h80
`define DLL_TYPE_UPDATEFC_NP   8'h90
`define DLL_TYPE_UPDATEFC_CPL  8'hA0
`define DLL_TYPE_INITFC2_P     8'hC0
`define DLL_TYPE_INITFC2_NP    8'hD0
`define DLL_TYPE_INITFC2_CPL   8'hE0

`endif
